// ==== hdl/spi_cfg_pkg.sv ====
`default_nettype none

// Frame level definitions shared by the register block and the shift engine.
package spi_cfg_pkg;

    // SPI mode. The polarity sits in the upper bit so the value reads as mode 0..3.
    typedef struct packed {
        logic cpol; // Idle level of sck.
        logic cpha; // 0 samples on the leading edge, 1 on the trailing edge.
    } spi_mode_t;

    // Divider select. One half period of sck is 2^(select+1) wr cycles.
    typedef logic [2:0] presc_sel_t;

    localparam int presc_w = 9; // Holds the largest half period of 256 cycles.

    localparam spi_mode_t  mode_rst  = '{cpol: 1'b0, cpha: 1'b0}; // Mode 0 after reset.
    localparam presc_sel_t presc_rst = 3'd0;                      // Fastest clock after reset.

endpackage

`default_nettype wire

// ==== hdl/apb_reg_pkg.sv ====
`default_nettype none

// Register map of the APB slave.
package apb_reg_pkg;

    localparam int apb_addr_w = 2;
    typedef logic [apb_addr_w-1:0] apb_addr_t; // Word address.

    localparam apb_addr_t addr_data   = 2'd0; // Transmit buffer on write, receive register on read.
    localparam apb_addr_t addr_ctrl   = 2'd1; // Divider select, mode and bit order.
    localparam apb_addr_t addr_status = 2'd2; // Flags. Writing 1 to send_err clears it.

    // Bit positions in the status register.
    localparam int st_tx_empty      = 0;
    localparam int st_char_received = 1;
    localparam int st_send_err      = 2;

    // Field positions in the control register.
    localparam int ctrl_presc_lsb = 0;
    localparam int ctrl_mode_lsb  = 3;
    localparam int ctrl_lsb_first = 5;

endpackage

`default_nettype wire

// ==== hdl/spi_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Divider for the SPI clock. Gives one tick per half period of sck.
module spi_clk_gen
    import spi_cfg_pkg::*;
(
    input  logic       wr,
    input  logic       rst,
    input  logic       run,       // Frame in progress.
    input  presc_sel_t presc_sel, // Half period is 2^(presc_sel+1) cycles.
    output logic       tick
);

    logic [presc_w-1:0] cnt;
    logic [presc_w-1:0] limit; // Last count value of a half period.

    // Select 0 gives 1, select 7 gives 255.
    assign limit = presc_w'((1 << (presc_sel + 1)) - 1);

    assign tick = (cnt == limit); // The count held at zero keeps this low while stopped.

    ////////////////////
    // Half period counter.

    // Holding the count at zero while idle makes the first
    // half period of a frame full length.
    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (!run || tick) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    a_no_tick_idle : assert property (
        @(posedge wr) disable iff (rst) !run |-> !tick
    ) else $error("tick while the divider is stopped");

endmodule

`default_nettype wire

// ==== hdl/spi_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Frame engine. Counts sck edges, shifts data in both directions and drives
// ss, sck and mosi.
module spi_shifter
    import spi_cfg_pkg::*;
#(
    parameter int word_len = 8
) (
    input  logic                wr,
    input  logic                rst,
    input  logic [word_len-1:0] tx_word,
    input  logic                tx_valid,
    input  presc_sel_t          presc_sel,
    input  spi_mode_t           mode,
    input  logic                lsb_first,
    output logic                tx_take,
    output logic [word_len-1:0] rx_word,
    output logic                rx_done,
    output logic                sck,
    output logic                mosi,
    input  logic                miso,
    output logic                ss
);

    // Edges 0 .. 2*word_len-1 toggle sck. Tick 2*word_len ends the frame.
    localparam int cnt_w = $clog2(2 * word_len + 1);
    localparam logic [cnt_w-1:0] last_edge = cnt_w'(2 * word_len - 1);
    localparam logic [cnt_w-1:0] tail_edge = cnt_w'(2 * word_len);

    typedef enum logic [1:0] {st_idle, st_start, st_busy} state_t;

    state_t              state;
    logic [cnt_w-1:0]    edge_cnt;    // Ticks seen in the current frame.
    logic                sck_ph;      // Internal phase, 0 at idle.
    logic                mosi_q;
    spi_mode_t           mode_q;      // Settings captured at frame start.
    logic                lsb_q;
    presc_sel_t          presc_q;
    logic [word_len-1:0] tx_sh;
    logic [word_len-1:0] rx_sh;
    logic [word_len-1:0] tx_sh_nxt;
    logic [word_len-1:0] rx_sh_nxt;
    logic [word_len-1:0] first_rest;  // New word with its first bit consumed.
    logic                first_bit;
    logic                tx_bit;
    logic                run;
    logic                tick;
    logic                at_tail;
    logic                shift_edge;
    logic                sample_edge;

    assign run         = (state == st_busy);
    assign at_tail     = (edge_cnt == tail_edge);
    assign shift_edge  = tick && !at_tail;              // Tick that moves sck.
    assign sample_edge = (edge_cnt[0] == mode_q.cpha);  // Even edges lead, odd edges trail.

    // Load from the start state, or at the tail when the next word is ready.
    assign tx_take = (state == st_start) || (run && tick && at_tail && tx_valid);
    assign rx_done = shift_edge && (edge_cnt == last_edge);

    // Bit order helpers. Vacated positions fill with 1.
    assign first_bit  = lsb_first ? tx_word[0] : tx_word[word_len-1];
    assign first_rest = lsb_first ? {1'b1, tx_word[word_len-1:1]} : {tx_word[word_len-2:0], 1'b1};
    assign tx_bit     = lsb_q ? tx_sh[0] : tx_sh[word_len-1];
    assign tx_sh_nxt  = lsb_q ? {1'b1, tx_sh[word_len-1:1]} : {tx_sh[word_len-2:0], 1'b1};
    assign rx_sh_nxt  = lsb_q ? {miso, rx_sh[word_len-1:1]} : {rx_sh[word_len-2:0], miso};

    // In modes 1 and 3 the last edge samples, so the final bit comes straight from miso.
    assign rx_word = (shift_edge && sample_edge) ? rx_sh_nxt : rx_sh;

    assign sck  = sck_ph ^ mode_q.cpol;
    assign mosi = ss ? 1'b1 : mosi_q; // Line idles high between frames.

    ////////////////////
    // Control state.

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            state    <= st_idle;
            edge_cnt <= '0;
            ss       <= 1'b1;
            sck_ph   <= 1'b0;
            mosi_q   <= 1'b1;
            mode_q   <= mode_rst;
            lsb_q    <= 1'b0;
            presc_q  <= presc_rst;
        end else if (tx_take) begin
            state    <= st_busy;
            edge_cnt <= '0;
            ss       <= 1'b0;
            sck_ph   <= 1'b0;
            mode_q   <= mode;
            lsb_q    <= lsb_first;
            presc_q  <= presc_sel;
            mosi_q   <= mode.cpha ? 1'b1 : first_bit; // Modes 0 and 2 present bit one now.
        end else begin
            case (state)
                st_idle: begin
                    if (tx_valid) begin
                        state <= st_start;
                    end
                end
                st_busy: begin
                    if (tick && at_tail) begin
                        state <= st_idle; // Nothing queued so release the slave.
                        ss    <= 1'b1;
                    end else if (shift_edge) begin
                        sck_ph   <= ~sck_ph;
                        edge_cnt <= edge_cnt + 1'b1;
                        if (!sample_edge) begin
                            mosi_q <= tx_bit;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    ////////////////////
    // Shift registers.

    always_ff @(posedge wr) begin
        if (tx_take) begin
            tx_sh <= mode.cpha ? tx_word : first_rest;
        end else if (shift_edge && !sample_edge) begin
            tx_sh <= tx_sh_nxt;
        end
        if (shift_edge && sample_edge) begin
            rx_sh <= rx_sh_nxt;
        end
    end

    spi_clk_gen spi_clk_gen_i (
        .wr        (wr),
        .rst       (rst),
        .run       (run),
        .presc_sel (presc_q),
        .tick      (tick)
    );

    // Every frame leaves sck back at its idle level.
    a_sck_idle : assert property (
        @(posedge wr) disable iff (rst) ss |-> (sck == mode_q.cpol)
    ) else $error("sck away from idle level while ss is high");

    a_done_busy : assert property (
        @(posedge wr) disable iff (rst) rx_done |-> (run && !ss)
    ) else $error("rx_done outside a frame");

endmodule

`default_nettype wire

// ==== hdl/spi_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// APB slave with zero wait states. Holds the control register, the one word
// transmit buffer, the receive register and the status flags.
module spi_apb_regs
    import spi_cfg_pkg::*, apb_reg_pkg::*;
#(
    parameter int word_len = 8
) (
    input  logic                wr,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_addr_t           paddr,
    input  logic [word_len-1:0] pwdata,
    output logic [word_len-1:0] prdata,
    output logic [word_len-1:0] tx_word,   // Transmit buffer.
    output logic                tx_valid,  // Buffer holds a word not yet taken.
    output presc_sel_t          presc_sel,
    output spi_mode_t           mode,
    output logic                lsb_first,
    input  logic                tx_take,   // Shifter empties the buffer.
    input  logic [word_len-1:0] rx_word,
    input  logic                rx_done    // Last sck edge of a frame.
);

    logic                wr_acc;        // Write access cycle.
    logic                rd_acc;        // Read access cycle.
    logic [word_len-1:0] rx_reg;        // Last received word.
    logic                char_received;
    logic                send_err;

    // The control fields need six data bits.
    if (word_len < 6) begin : g_width_check
        $error("spi_apb_regs needs word_len of at least 6");
    end

    assign wr_acc = psel && penable && pwrite;
    assign rd_acc = psel && penable && !pwrite;

    ////////////////////
    // Control register and flags.

    always_ff @(posedge wr or posedge rst) begin
        if (rst) begin
            presc_sel     <= presc_rst;
            mode          <= mode_rst;
            lsb_first     <= 1'b0;
            tx_valid      <= 1'b0;
            char_received <= 1'b0;
            send_err      <= 1'b0;
        end else begin
            if (wr_acc && paddr == addr_ctrl) begin
                presc_sel <= pwdata[ctrl_presc_lsb +: 3];
                mode      <= spi_mode_t'(pwdata[ctrl_mode_lsb +: 2]);
                lsb_first <= pwdata[ctrl_lsb_first];
            end
            // A full buffer refuses the new word and flags the loss.
            if (wr_acc && paddr == addr_data && tx_valid) begin
                send_err <= 1'b1;
            end else if (wr_acc && paddr == addr_status && pwdata[st_send_err]) begin
                send_err <= 1'b0;
            end
            if (wr_acc && paddr == addr_data && !tx_valid) begin
                tx_valid <= 1'b1;
            end else if (tx_take) begin
                tx_valid <= 1'b0; // Shifter has copied the word.
            end
            // A new word wins over a read in the same cycle.
            if (rx_done) begin
                char_received <= 1'b1;
            end else if (rd_acc && paddr == addr_data) begin
                char_received <= 1'b0;
            end
        end
    end

    ////////////////////
    // Data words.

    always_ff @(posedge wr) begin
        if (wr_acc && paddr == addr_data && !tx_valid) begin
            tx_word <= pwdata;
        end
        if (rx_done) begin
            rx_reg <= rx_word;
        end
    end

    // Read data is valid throughout the access cycle.
    always_comb begin
        prdata = '0;
        case (paddr)
            addr_data: prdata = rx_reg;
            addr_ctrl: begin
                prdata[ctrl_presc_lsb +: 3] = presc_sel;
                prdata[ctrl_mode_lsb +: 2]  = mode;
                prdata[ctrl_lsb_first]      = lsb_first;
            end
            addr_status: begin
                prdata[st_tx_empty]      = !tx_valid;
                prdata[st_char_received] = char_received;
                prdata[st_send_err]      = send_err;
            end
            default: prdata = '0; // Unmapped address reads zero.
        endcase
    end

    // The shifter only takes a word the buffer actually holds.
    a_take_needs_valid : assert property (
        @(posedge wr) disable iff (rst) tx_take |-> tx_valid
    ) else $error("tx_take while the transmit buffer is empty");

endmodule

`default_nettype wire

// ==== hdl/spi_apb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

// SPI master with an APB register interface.
module spi_apb_master
    import spi_cfg_pkg::*, apb_reg_pkg::*;
#(
    parameter int word_len = 8 // Also the APB data width.
) (
    input  logic                wr,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  apb_addr_t           paddr,
    input  logic [word_len-1:0] pwdata,
    output logic [word_len-1:0] prdata,
    output logic                sck,
    output logic                mosi,
    input  logic                miso,
    output logic                ss
);

    // Handshake and settings between the register block and the shift engine.
    logic [word_len-1:0] tx_word;
    logic                tx_valid;
    logic                tx_take;
    logic [word_len-1:0] rx_word;
    logic                rx_done;
    presc_sel_t          presc_sel;
    spi_mode_t           mode;
    logic                lsb_first;

    spi_apb_regs #(
        .word_len (word_len)
    ) spi_apb_regs_i (
        .wr        (wr),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .tx_word   (tx_word),
        .tx_valid  (tx_valid),
        .presc_sel (presc_sel),
        .mode      (mode),
        .lsb_first (lsb_first),
        .tx_take   (tx_take),
        .rx_word   (rx_word),
        .rx_done   (rx_done)
    );

    spi_shifter #(
        .word_len (word_len)
    ) spi_shifter_i (
        .wr        (wr),
        .rst       (rst),
        .tx_word   (tx_word),
        .tx_valid  (tx_valid),
        .presc_sel (presc_sel),
        .mode      (mode),
        .lsb_first (lsb_first),
        .tx_take   (tx_take),
        .rx_word   (rx_word),
        .rx_done   (rx_done),
        .sck       (sck),
        .mosi      (mosi),
        .miso      (miso),
        .ss        (ss)
    );

endmodule

`default_nettype wire

// ==== tb/tb_spi_tasks.svh ====
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// Galois LFSR, one step per bit taken.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);
        v = {v[30:0], lfsr[0]};
    end
endtask

task automatic fill_slave_words();
    logic [31:0] r;
    for (int i = 0; i < 16; i++) begin
        draw_bits(word_len, r);
        slave_words[i] = r[word_len-1:0];
    end
endtask

////////////////////
// APB access.

task automatic apb_write(input apb_addr_t a, input logic [word_len-1:0] d);
    @(posedge wr);
    #1 psel = 1'b1; // Setup cycle.
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = a;
    pwdata = d;
    @(posedge wr);
    #1 penable = 1'b1;
    @(posedge wr); // The write takes effect at this edge.
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic apb_read(input apb_addr_t a, output logic [word_len-1:0] d);
    @(posedge wr);
    #1 psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = a;
    @(posedge wr);
    #1 penable = 1'b1;
    @(negedge wr);
    d = prdata; // Mid access cycle.
    @(posedge wr);
    #1 psel = 1'b0;
    penable = 1'b0;
endtask

// Hands one value to the compare assertion for a single cycle.
task automatic check_value(input logic [word_len-1:0] got, input logic [word_len-1:0] exp,
                           input string msg);
    cmp_got = got;
    cmp_exp = exp;
    cmp_msg = msg;
    cmp_ev = 1'b1;
    @(posedge wr);
    #1 cmp_ev = 1'b0;
endtask

task automatic check_read(input apb_addr_t a, input logic [word_len-1:0] exp, input string msg);
    logic [word_len-1:0] v;
    apb_read(a, v);
    check_value(v, exp, msg);
endtask

// Waits until ss reaches the level, bounded by the slowest burst.
task automatic wait_ss(input logic level);
    int n;
    n = 0;
    while (ss !== level && n < 3 * max_frame_cyc) begin
        @(posedge wr);
        #1 n++;
    end
    if (ss !== level) begin
        errors++;
        $display("ss never went %s, the transfer is stuck", level ? "high" : "low");
    end
endtask

task automatic report_test(input string name, input int e0);
    $display("Test %s finished with %0d errors", name, errors - e0);
endtask

////////////////////
// Tests.

task automatic test_reset();
    check_value(word_len'({ss, sck, mosi}), word_len'(3'b101), "ss, sck, mosi after reset");
    check_read(addr_status, 8'h01, "STATUS after reset");
endtask

// Every mode in both bit orders, one frame each at a random divider.
task automatic test_modes();
    logic [31:0] r;
    for (int m = 0; m < 4; m++) begin
        for (int l = 0; l < 2; l++) begin
            draw_bits(3, r);
            cur_sel = r[2:0];
            cur_mode = m[1:0];
            cur_lsb = l[0];
            apb_write(addr_ctrl, {2'b00, cur_lsb, cur_mode, cur_sel});
            draw_bits(word_len, r);
            exp_q.push_back(r[word_len-1:0]);
            exp_burst = 1;
            apb_write(addr_data, r[word_len-1:0]);
            wait_ss(1'b0);
            wait_ss(1'b1);
            check_read(addr_status, 8'h03, "STATUS before DATA read");
            check_read(addr_data, slave_words[frames_sent], "DATA");
            frames_sent++;
            check_read(addr_status, 8'h01, "STATUS after DATA read");
        end
    end
endtask

// Second word queued during the first frame, third word refused.
task automatic test_back_to_back();
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    cur_sel = 3'd1;
    cur_mode = 2'd0;
    cur_lsb = 1'b0;
    apb_write(addr_ctrl, 8'h01);
    draw_bits(word_len, w1);
    draw_bits(word_len, w2);
    draw_bits(word_len, w3);
    exp_q.push_back(w1[word_len-1:0]);
    exp_q.push_back(w2[word_len-1:0]);
    exp_burst = 2;
    apb_write(addr_data, w1[word_len-1:0]);
    wait_ss(1'b0);
    apb_write(addr_data, w2[word_len-1:0]);
    apb_write(addr_data, w3[word_len-1:0]); // Buffer still holds w2.
    wait_ss(1'b1);
    check_read(addr_status, 8'h07, "STATUS after overrun");
    apb_write(addr_status, 8'h04);
    check_read(addr_status, 8'h03, "STATUS after send_err clear");
    check_read(addr_data, slave_words[frames_sent + 1], "DATA after burst");
    frames_sent += 2;
    check_read(addr_status, 8'h01, "STATUS at end");
endtask

`endif

// ==== tb/tb_spi_apb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_spi_apb_master
    import apb_reg_pkg::*;
();

    localparam int word_len = 8;
    localparam int n_frames = 12;                            // Data frames in all tests, rounded up.
    localparam int max_frame_cyc = (2 * word_len + 4) * 256; // Slowest divider plus slack.
    localparam longint wd_ns = 100 * (longint'(n_frames) * max_frame_cyc + 2000);

    logic                wr;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    apb_addr_t           paddr;
    logic [word_len-1:0] pwdata;
    logic [word_len-1:0] prdata;
    logic                sck;
    logic                mosi;
    logic                miso;
    logic                ss;

    int                  errors = 0;
    logic [31:0]         lfsr;
    logic [word_len-1:0] exp_q[$];       // Words the slave must receive, in order.
    logic [word_len-1:0] slave_words[16]; // Words the slave sends, one per frame.
    int                  frames_sent = 0;

    // Settings of the next frame, set by the tests before the DATA write.
    logic [1:0]          cur_mode = 2'd0;
    logic                cur_lsb = 1'b0;
    logic [2:0]          cur_sel = 3'd0;
    int                  exp_burst = 1;  // Frames expected while ss stays low.

    // Value compare handshake used by the register checks.
    logic                cmp_ev = 1'b0;
    logic [word_len-1:0] cmp_got;
    logic [word_len-1:0] cmp_exp;
    string               cmp_msg;

    ////////////////////
    // Clock, DUT.

    initial begin
        wr = 1'b0;
        forever #50 wr = ~wr; // 100 ns period.
    end

    spi_apb_master #(
        .word_len (word_len)
    ) spi_apb_master_i (
        .wr      (wr),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .sck     (sck),
        .mosi    (mosi),
        .miso    (miso),
        .ss      (ss)
    );

    ////////////////////
    // SPI slave model.

    // The model runs on the falling wr edge, where every DUT output is settled.
    logic [1:0]          f_mode;
    logic                f_lsb;
    logic [2:0]          f_sel = 3'd0;
    logic                idle_cpol = 1'b0; // Polarity of the last started frame.
    logic                ss_q = 1'b1;
    logic                sck_q = 1'b0;
    logic                leading;
    logic [word_len-1:0] rx_sh;
    int                  edges = 0;        // sck edges in the current frame.
    int                  drv_n = 0;        // Bits already put on miso.
    int                  frame_idx = 0;
    int                  burst_frames = 0;
    int                  half_cnt = 0;     // wr cycles since the last event.
    logic                rx_ev = 1'b0;
    logic                rx_had;
    logic [word_len-1:0] rx_got;
    logic [word_len-1:0] rx_exp;
    logic                hp_ev = 1'b0;
    int                  hp_got;
    int                  hp_exp;
    logic                burst_ev = 1'b0;
    int                  burst_got;
    int                  burst_partial;

    assign hp_exp = 1 << (f_sel + 1); // Half period in wr cycles.

    function automatic logic slave_bit(input int n);
        return f_lsb ? slave_words[frame_idx][n] : slave_words[frame_idx][word_len-1-n];
    endfunction

    // Modes 0 and 2 need the first bit on miso before the first edge.
    task automatic start_word();
        drv_n = 0;
        if (!f_mode[0]) begin
            miso = slave_bit(0);
            drv_n = 1;
        end
    endtask

    always @(negedge wr) begin
        rx_ev = 1'b0;
        hp_ev = 1'b0;
        burst_ev = 1'b0;
        half_cnt++;
        if (ss_q && !ss) begin
            f_mode = cur_mode;    // The DUT captured the same settings at this edge.
            f_lsb = cur_lsb;
            f_sel = cur_sel;
            idle_cpol = cur_mode[1];
            edges = 0;
            burst_frames = 0;
            half_cnt = 0;
            start_word();
        end else if (!ss && !ss_q && sck != sck_q) begin
            leading = (sck_q == f_mode[1]); // Edge away from the idle level.
            // The first half period of a burst runs from the ss fall.
            if (edges > 0 || burst_frames == 0) begin
                hp_got = half_cnt;
                hp_ev = 1'b1;
            end
            half_cnt = 0;
            if (leading != f_mode[0]) begin
                rx_sh = f_lsb ? {mosi, rx_sh[word_len-1:1]} : {rx_sh[word_len-2:0], mosi};
            end else if (drv_n < word_len) begin
                miso = slave_bit(drv_n);
                drv_n++;
            end
            edges++;
            if (edges == 2 * word_len) begin
                rx_ev = 1'b1;
                rx_got = rx_sh;
                rx_had = (exp_q.size() > 0);
                if (rx_had) rx_exp = exp_q.pop_front();
                frame_idx++;
                burst_frames++;
                edges = 0;
                start_word(); // A queued word follows without a gap.
            end
        end else if (!ss_q && ss) begin
            hp_got = half_cnt;   // ss rises one half period after the last edge.
            hp_ev = 1'b1;
            burst_ev = 1'b1;
            burst_got = burst_frames;
            burst_partial = edges;
        end
        ss_q = ss;
        sck_q = sck;
    end

    ////////////////////
    // Checks.

    a_rx_word : assert property (@(posedge wr) disable iff (rst)
        rx_ev |-> (rx_had && rx_got == rx_exp))
        else begin
            errors++;
            $display("[ERROR] %0t: slave received %h, expected %h", $time, rx_got, rx_exp);
        end

    a_half_period : assert property (@(posedge wr) disable iff (rst) hp_ev |-> hp_got == hp_exp)
        else begin
            errors++;
            $display("[ERROR] %0t: half period of %0d cycles, expected %0d",
                     $time, hp_got, hp_exp);
        end

    // A burst holds whole frames only, and exactly as many as were queued.
    a_burst : assert property (@(posedge wr) disable iff (rst)
        burst_ev |-> (burst_got == exp_burst && burst_partial == 0))
        else begin
            errors++;
            $display("[ERROR] %0t: ss low for %0d frames plus %0d edges, expected %0d frames",
                     $time, burst_got, burst_partial, exp_burst);
        end

    a_idle_sck : assert property (@(posedge wr) disable iff (rst) ss |-> sck == idle_cpol)
        else begin
            errors++;
            $display("[ERROR] %0t: sck is %b while ss is high", $time, sck);
        end

    a_idle_mosi : assert property (@(posedge wr) disable iff (rst) ss |-> mosi)
        else begin
            errors++;
            $display("[ERROR] %0t: mosi low while ss is high", $time);
        end

    a_compare : assert property (@(posedge wr) cmp_ev |-> cmp_got == cmp_exp)
        else begin
            errors++;
            $display("[ERROR] %0t: %s read %h, expected %h", $time, cmp_msg, cmp_got, cmp_exp);
        end

    `include "tb_spi_tasks.svh"

    ////////////////////
    // Main sequence.

    initial begin
        int e0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        miso = 1'b1;
        lfsr = 32'hc5a0_b239;
        fill_slave_words();
        repeat (3) @(posedge wr);
        #1 rst = 1'b0;

        e0 = errors;
        test_reset();
        report_test("reset state", e0);
        e0 = errors;
        test_modes();
        report_test("modes and bit orders", e0);
        e0 = errors;
        test_back_to_back();
        report_test("back-to-back and overrun", e0);

        $display("Tests run: 3, errors: %0d", errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Ends a run that hangs, sized for the slowest frames.
    initial begin
        #(wd_ns);
        $display("Watchdog expired: the tests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== spi_apb.f ====
hdl/spi_cfg_pkg.sv
hdl/apb_reg_pkg.sv
hdl/spi_clk_gen.sv
hdl/spi_shifter.sv
hdl/spi_apb_regs.sv
hdl/spi_apb_master.sv
+incdir+tb
tb/tb_spi_apb_master.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_apb_master \
		-f spi_apb.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
